//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module skirocAcqTb \
    -f skirocAcq.f -o skirocAcqSim || exit 1

./obj_dir/skirocAcqSim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log

# The log decides the result
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0

//--- skirocAcq.f
+incdir+tests
verilog/skirocAcqPkg.sv
verilog/chipSignalSync.sv
verilog/phaseTimer.sv
verilog/acqSequencer.sv
verilog/trigCounter.sv
verilog/skirocAcq.sv
tests/skirocAcqTb.sv

//--- tests/skirocAcqChecks.svh
`ifndef SKIROC_ACQ_CHECKS_SVH
`define SKIROC_ACQ_CHECKS_SVH

////////////////////////////////////////////////////////////////////////////
// Random numbers, expected values and measurement helpers
////////////////////////////////////////////////////////////////////////////

// 16-bit Fibonacci LFSR, x^16 + x^15 + x^13 + x^4 + 1
function automatic logic stepLfsr();
    logic feedback;
    feedback  = lfsrState[15] ^ lfsrState[14] ^ lfsrState[12] ^ lfsrState[3];
    lfsrState = {lfsrState[14:0], feedback};
    return feedback;
endfunction

function automatic int takeBits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++)
        value = (value << 1) | int'(stepLfsr());
    return value;
endfunction

// Chip response delay, 3 to 10 cycles
function automatic int responseDelay();
    return 3 + takeBits(3);
endfunction

// Expected cycle counts from the timing rules
function automatic int expectedValue(input int kind, input int arg);
    case (kind)
        KindResetWidth:   return ResetCycles + 1;
        KindConvbWidth:   return ConvbCycles + 1;
        KindReadoutWidth: return ReadoutCycles + 1;
        KindRiseTimeout:  return WaitToReadoutCycles + 1;   // StartConvb rise to StartReadout rise
        KindEndTimeout:   return WaitToEndCycles + 1 + WaitToNextCycles + 1;
        KindTrigCount:    return arg;
        default:          return -1;
    endcase
endfunction

// Longest full cycle with the slowest chip answers
function automatic int cycleLength();
    return ResetCycles + WaitToAcqCycles + WaitToConvbCycles + ConvbCycles
         + WaitToReadoutCycles + ReadoutCycles + WaitToEndCycles + WaitToNextCycles
         + 8 + 3 * (10 + 4);
endfunction

task automatic checkValue(input string name, input int expected, input int actual);
    checkCount++;
    if (expected != actual)
    begin
        errorCount++;
        $display("ERROR %s expected %0d actual %0d", name, expected, actual);
    end
endtask

// Waits for a fresh transition of the selected output to the given level
task automatic waitEdge(input int sel, input logic level);
    while (outputBit(sel) == level)
        @(negedge Clk);
    while (outputBit(sel) != level)
        @(negedge Clk);
endtask

task automatic measureWidth(input int sel, input logic level, output int width);
    width = 0;
    while (outputBit(sel) == level)
    begin
        width++;
        @(negedge Clk);
    end
endtask

task automatic cyclesUntil(input int sel, input logic level, output int cycles);
    cycles = 0;
    while (outputBit(sel) != level)
    begin
        cycles++;
        @(negedge Clk);
    end
endtask

`endif

//--- tests/skirocAcqTb.sv
`timescale 1ns/1ps
`default_nettype none

module skirocAcqTb;

    localparam int ResetCycles         = 5;
    localparam int WaitToAcqCycles     = 4;
    localparam int WaitToConvbCycles   = 4;
    localparam int ConvbCycles         = 2;
    localparam int WaitToReadoutCycles = 30;
    localparam int ReadoutCycles       = 6;
    localparam int WaitToEndCycles     = 40;
    localparam int WaitToNextCycles    = 4;
    localparam int ClkPeriod           = 4;

    // Expected value kinds
    localparam int KindResetWidth   = 0;
    localparam int KindConvbWidth   = 1;
    localparam int KindReadoutWidth = 2;
    localparam int KindRiseTimeout  = 3;
    localparam int KindEndTimeout   = 4;
    localparam int KindTrigCount    = 5;

    // Output selectors
    localparam int SelResetbAsic   = 0;
    localparam int SelStartAcq     = 1;
    localparam int SelStartConvb   = 2;
    localparam int SelStartReadout = 3;

    logic Clk;
    logic Rst_N;
    logic StartWork;
    logic Chipsatb;
    logic EndReadout;
    logic ExTrig;
    logic Acqing;
    logic StartAcq;
    logic StartConvb;
    logic StartReadout;
    logic PwrOnD;
    logic ResetbAsic;
    skirocAcqPkg::trigCountT TrigCount;

    logic [15:0] lfsrState = 16'd14;
    int          checkCount = 0;
    int          errorCount = 0;
    int          testCount = 0;
    logic        holdRise = 1'b0;   // Chip model withholds the Chipsatb rise
    logic        holdEnd = 1'b0;    // Chip model withholds EndReadout

    function automatic logic outputBit(input int sel);
        case (sel)
            SelResetbAsic:   return ResetbAsic;
            SelStartAcq:     return StartAcq;
            SelStartConvb:   return StartConvb;
            default:         return StartReadout;
        endcase
    endfunction

    `include "skirocAcqChecks.svh"

    skirocAcq
    #(
        .ResetCycles         (ResetCycles),
        .WaitToAcqCycles     (WaitToAcqCycles),
        .WaitToConvbCycles   (WaitToConvbCycles),
        .ConvbCycles         (ConvbCycles),
        .WaitToReadoutCycles (WaitToReadoutCycles),
        .ReadoutCycles       (ReadoutCycles),
        .WaitToEndCycles     (WaitToEndCycles),
        .WaitToNextCycles    (WaitToNextCycles)
    )
    skirocAcq_inst
    (
        .Clk          (Clk),
        .Rst_N        (Rst_N),
        .StartWork    (StartWork),
        .Chipsatb     (Chipsatb),
        .EndReadout   (EndReadout),
        .ExTrig       (ExTrig),
        .Acqing       (Acqing),
        .StartAcq     (StartAcq),
        .StartConvb   (StartConvb),
        .StartReadout (StartReadout),
        .PwrOnD       (PwrOnD),
        .ResetbAsic   (ResetbAsic),
        .TrigCount    (TrigCount)
    );

    initial
        Clk = 1'b0;

    always #(ClkPeriod / 2) Clk = !Clk;

    ////////////////////////////////////////////////////////////////////////////
    // Chip model
    ////////////////////////////////////////////////////////////////////////////

    int   dropCnt = -1;
    int   riseCnt = -1;
    int   endCnt = -1;
    int   endHighCnt = 0;
    logic prevStartAcq = 1'b0;
    logic prevStartConvb = 1'b1;
    logic prevStartReadout = 1'b0;

    always @(negedge Clk)
    begin
        if (StartAcq && !prevStartAcq)
            dropCnt = responseDelay();          // Memory fills after a while
        else if (!StartAcq && prevStartAcq && dropCnt > 0)
            dropCnt = -1;                       // Run stopped before saturation
        if (StartConvb && !prevStartConvb && !holdRise)
            riseCnt = responseDelay();
        if (!StartReadout && prevStartReadout)
        begin
            Chipsatb = 1'b1;                    // Ready again for the next round
            if (!holdEnd)
                endCnt = responseDelay();
        end

        if (dropCnt > 0)
            dropCnt--;
        else if (dropCnt == 0)
        begin
            Chipsatb = 1'b0;
            dropCnt  = -1;
        end
        if (riseCnt > 0)
            riseCnt--;
        else if (riseCnt == 0)
        begin
            Chipsatb = 1'b1;
            riseCnt  = -1;
        end
        if (endHighCnt > 0)
        begin
            endHighCnt--;
            if (endHighCnt == 0)
                EndReadout = 1'b0;
        end
        if (endCnt > 0)
            endCnt--;
        else if (endCnt == 0)
        begin
            EndReadout = 1'b1;
            endHighCnt = 3;
            endCnt     = -1;
        end

        prevStartAcq     = StartAcq;
        prevStartConvb   = StartConvb;
        prevStartReadout = StartReadout;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkIdleOutputs(input string name);
        checkValue({name, " Acqing"}, 0, int'(Acqing));
        checkValue({name, " StartAcq"}, 0, int'(StartAcq));
        checkValue({name, " StartConvb"}, 1, int'(StartConvb));
        checkValue({name, " StartReadout"}, 0, int'(StartReadout));
        checkValue({name, " PwrOnD"}, 0, int'(PwrOnD));
        checkValue({name, " ResetbAsic"}, 1, int'(ResetbAsic));
        checkValue({name, " TrigCount"}, 0, int'(TrigCount));
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore)
            $display("%s: pass", name);
        else
            $display("%s: fail", name);
    endtask

    task automatic sendTriggers(input int count);
        repeat (count)
        begin
            ExTrig = 1'b1;
            repeat (3) @(negedge Clk);
            ExTrig = 1'b0;
            repeat (3) @(negedge Clk);
        end
    endtask

    initial
    begin
        int errorsBefore;
        int width;
        int cycles;
        int trigSent;
        int acqSeen;

        Rst_N      = 1'b0;
        StartWork  = 1'b0;
        Chipsatb   = 1'b1;
        EndReadout = 1'b0;
        ExTrig     = 1'b0;
        repeat (5) @(negedge Clk);
        Rst_N = 1'b1;

        // Reset values
        errorsBefore = errorCount;
        checkIdleOutputs("reset values");
        repeat (10) @(negedge Clk);
        checkIdleOutputs("reset values idle");
        finishTest("reset values", errorsBefore);

        // Strobe widths and order in one full cycle
        errorsBefore = errorCount;
        StartWork = 1'b1;
        waitEdge(SelResetbAsic, 1'b0);
        checkValue("pwrond in reset", 1, int'(PwrOnD));
        measureWidth(SelResetbAsic, 1'b0, width);
        checkValue("reset width", expectedValue(KindResetWidth, 0), width);
        waitEdge(SelStartAcq, 1'b1);
        checkValue("acqing with startacq", 1, int'(Acqing));
        measureWidth(SelStartAcq, 1'b1, width);
        checkValue("chipsatb low at acq end", 0, int'(Chipsatb));
        waitEdge(SelStartConvb, 1'b0);
        checkValue("pwrond in convert", 1, int'(PwrOnD));
        measureWidth(SelStartConvb, 1'b0, width);
        checkValue("convb width", expectedValue(KindConvbWidth, 0), width);
        waitEdge(SelStartReadout, 1'b1);
        checkValue("chipsatb high at readout", 1, int'(Chipsatb));
        checkValue("pwrond in readout", 0, int'(PwrOnD));
        measureWidth(SelStartReadout, 1'b1, width);
        checkValue("readout width", expectedValue(KindReadoutWidth, 0), width);
        finishTest("strobe widths", errorsBefore);

        // Second cycle follows the end of readout
        errorsBefore = errorCount;
        waitEdge(SelResetbAsic, 1'b0);
        measureWidth(SelResetbAsic, 1'b0, width);
        checkValue("repeat reset width", expectedValue(KindResetWidth, 0), width);
        waitEdge(SelStartReadout, 1'b1);
        measureWidth(SelStartReadout, 1'b1, width);
        checkValue("repeat readout width", expectedValue(KindReadoutWidth, 0), width);
        finishTest("repetition", errorsBefore);

        // Trigger count while the run goes on
        errorsBefore = errorCount;
        trigSent = 2 + takeBits(3);
        sendTriggers(trigSent);
        repeat (4) @(negedge Clk);
        checkValue("trigger count", expectedValue(KindTrigCount, trigSent), int'(TrigCount));
        finishTest("trigger count", errorsBefore);

        // Timeouts with both chip answers withheld
        errorsBefore = errorCount;
        waitEdge(SelResetbAsic, 1'b0);
        holdRise = 1'b1;
        holdEnd  = 1'b1;
        waitEdge(SelStartConvb, 1'b0);
        measureWidth(SelStartConvb, 1'b0, width);
        cyclesUntil(SelStartReadout, 1'b1, cycles);
        checkValue("readout timeout", expectedValue(KindRiseTimeout, 0), cycles);
        measureWidth(SelStartReadout, 1'b1, width);
        cyclesUntil(SelResetbAsic, 1'b0, cycles);
        checkValue("end timeout", expectedValue(KindEndTimeout, 0), cycles);
        holdRise = 1'b0;
        holdEnd  = 1'b0;
        finishTest("timeouts", errorsBefore);

        // Stop during acquisition
        errorsBefore = errorCount;
        waitEdge(SelStartAcq, 1'b1);
        repeat (2) @(negedge Clk);
        StartWork = 1'b0;
        cyclesUntil(SelStartAcq, 1'b0, cycles);
        // State leaves Acquire on the next edge, the strobe one edge later
        checkValue("stop startacq fall", 2, cycles);
        waitEdge(SelStartConvb, 1'b0);
        measureWidth(SelStartConvb, 1'b0, width);
        checkValue("stop convb width", expectedValue(KindConvbWidth, 0), width);
        waitEdge(SelResetbAsic, 1'b0);
        measureWidth(SelResetbAsic, 1'b0, width);
        checkValue("stop reset width", expectedValue(KindResetWidth, 0), width);
        repeat (2) @(negedge Clk);
        acqSeen = 0;
        repeat (60)
        begin
            if (StartAcq)
                acqSeen++;
            @(negedge Clk);
        end
        checkValue("no acquisition after stop", 0, acqSeen);
        checkIdleOutputs("stop idle");
        finishTest("stop", errorsBefore);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // Watchdog with a budget from the phase durations
    initial
    begin
        int budget;

        budget = 8 * cycleLength() + 400;
        #(budget * ClkPeriod);
        $display("Simulation did not finish within %0d clock cycles", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/acqSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module acqSequencer
(
    input  wire                    Clk,
    input  wire                    Rst_N,
    input  wire                    StartWork,
    input  wire                    ChipsatbFall,
    input  wire                    ChipsatbRise,
    input  wire                    EndReadoutRise,
    input  wire                    PhaseDone,
    output skirocAcqPkg::seqStateT Phase,
    output logic                   Restart,
    output logic                   Idle,
    output logic                   Acqing,
    output logic                   StartAcq,
    output logic                   StartConvb,
    output logic                   StartReadout,
    output logic                   PwrOnD,
    output logic                   ResetbAsic
);

    skirocAcqPkg::seqStateT state;
    skirocAcqPkg::seqStateT nextState;

    ////////////////////////////////////////////////////////////////////////////
    // Phase FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
            state <= skirocAcqPkg::Idle;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = state;
        case (state)
            skirocAcqPkg::Idle:
            begin
                if (StartWork)
                    nextState = skirocAcqPkg::Reset;
            end
            skirocAcqPkg::Reset:
            begin
                // A stopped run ends here, after its last ASIC reset
                if (PhaseDone)
                    nextState = StartWork ? skirocAcqPkg::WaitToAcq : skirocAcqPkg::Idle;
            end
            skirocAcqPkg::WaitToAcq:
            begin
                if (PhaseDone)
                    nextState = skirocAcqPkg::Acquire;
            end
            skirocAcqPkg::Acquire:
            begin
                if (ChipsatbFall || !StartWork)     // Memory full, or stop forces conversion
                    nextState = skirocAcqPkg::WaitToConvb;
            end
            skirocAcqPkg::WaitToConvb:
            begin
                if (PhaseDone)
                    nextState = skirocAcqPkg::Convert;
            end
            skirocAcqPkg::Convert:
            begin
                if (PhaseDone)
                    nextState = skirocAcqPkg::WaitToReadout;
            end
            skirocAcqPkg::WaitToReadout:
            begin
                if (ChipsatbRise || PhaseDone)
                    nextState = skirocAcqPkg::Readout;
            end
            skirocAcqPkg::Readout:
            begin
                if (PhaseDone)
                    nextState = skirocAcqPkg::WaitToEnd;
            end
            skirocAcqPkg::WaitToEnd:
            begin
                if (EndReadoutRise || PhaseDone)
                    nextState = skirocAcqPkg::WaitToNext;
            end
            skirocAcqPkg::WaitToNext:
            begin
                if (PhaseDone)
                    nextState = skirocAcqPkg::Reset;
            end
            default:
                nextState = skirocAcqPkg::Idle;
        endcase
    end

    assign Phase   = state;
    assign Restart = (nextState != state);  // Timer starts from zero in each phase
    assign Idle    = (state == skirocAcqPkg::Idle);

    ////////////////////////////////////////////////////////////////////////////
    // Chip control outputs, one cycle behind the state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            Acqing       <= 1'b0;
            StartAcq     <= 1'b0;
            StartConvb   <= 1'b1;
            StartReadout <= 1'b0;
            PwrOnD       <= 1'b0;
            ResetbAsic   <= 1'b1;
        end
        else
        begin
            Acqing       <= (state == skirocAcqPkg::Acquire);
            StartAcq     <= (state == skirocAcqPkg::Acquire);
            StartConvb   <= (state != skirocAcqPkg::Convert);   // Active low
            StartReadout <= (state == skirocAcqPkg::Readout);
            ResetbAsic   <= (state != skirocAcqPkg::Reset);     // Active low

            // Power pulsing, analog part on until readout starts
            PwrOnD       <= state inside {skirocAcqPkg::Reset, skirocAcqPkg::WaitToAcq,
                                          skirocAcqPkg::Acquire, skirocAcqPkg::WaitToConvb,
                                          skirocAcqPkg::Convert, skirocAcqPkg::WaitToReadout};
        end
    end

endmodule

`default_nettype wire

//--- verilog/chipSignalSync.sv
`timescale 1ns/1ps
`default_nettype none

module chipSignalSync
(
    input  wire  Clk,
    input  wire  Rst_N,
    input  wire  Chipsatb,
    input  wire  EndReadout,
    input  wire  ExTrig,
    output logic ChipsatbFall,
    output logic ChipsatbRise,
    output logic EndReadoutRise,
    output logic ExTrigRise
);

    // Bit positions in the synchronizer vectors
    localparam int ChipsatbBit   = 0;
    localparam int EndReadoutBit = 1;
    localparam int ExTrigBit     = 2;

    // Chipsatb idles high, the others idle low
    localparam logic [2:0] IdleLevel = 3'b001;

    logic [2:0] syncStage1;
    logic [2:0] syncStage2;

    ////////////////////////////////////////////////////////////////////////////
    // Two-flop synchronizers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            syncStage1 <= IdleLevel;
            syncStage2 <= IdleLevel;
        end
        else
        begin
            syncStage1 <= {ExTrig, EndReadout, Chipsatb};
            syncStage2 <= syncStage1;
        end
    end

    // Registered edge pulses, one cycle wide
    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            ChipsatbFall   <= 1'b0;
            ChipsatbRise   <= 1'b0;
            EndReadoutRise <= 1'b0;
            ExTrigRise     <= 1'b0;
        end
        else
        begin
            ChipsatbFall   <= !syncStage1[ChipsatbBit] && syncStage2[ChipsatbBit];  // Memory full
            ChipsatbRise   <= syncStage1[ChipsatbBit] && !syncStage2[ChipsatbBit];  // Chip ready
            EndReadoutRise <= syncStage1[EndReadoutBit] && !syncStage2[EndReadoutBit];
            ExTrigRise     <= syncStage1[ExTrigBit] && !syncStage2[ExTrigBit];
        end
    end

endmodule

`default_nettype wire

//--- verilog/phaseTimer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseTimer
#(
    parameter skirocAcqPkg::countT ResetCycles         = 25,
    parameter skirocAcqPkg::countT WaitToAcqCycles     = 50,
    parameter skirocAcqPkg::countT WaitToConvbCycles   = 50,
    parameter skirocAcqPkg::countT ConvbCycles         = 2,
    parameter skirocAcqPkg::countT WaitToReadoutCycles = 250000,
    parameter skirocAcqPkg::countT ReadoutCycles       = 25,
    parameter skirocAcqPkg::countT WaitToEndCycles     = 250000,
    parameter skirocAcqPkg::countT WaitToNextCycles    = 50
)
(
    input  wire                    Clk,
    input  wire                    Rst_N,
    input  skirocAcqPkg::seqStateT Phase,
    input  wire                    Restart,
    output logic                   PhaseDone
);

    skirocAcqPkg::countT count;
    skirocAcqPkg::countT limit;
    logic                hasLimit;

    // Cycles spent in the current phase, zero on its first cycle
    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
            count <= '0;
        else if (Restart)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    always_comb
    begin
        limit    = '0;
        hasLimit = 1'b1;
        case (Phase)
            skirocAcqPkg::Reset:         limit = ResetCycles;
            skirocAcqPkg::WaitToAcq:     limit = WaitToAcqCycles;
            skirocAcqPkg::WaitToConvb:   limit = WaitToConvbCycles;
            skirocAcqPkg::Convert:       limit = ConvbCycles;
            skirocAcqPkg::WaitToReadout: limit = WaitToReadoutCycles;   // Timeout
            skirocAcqPkg::Readout:       limit = ReadoutCycles;
            skirocAcqPkg::WaitToEnd:     limit = WaitToEndCycles;       // Timeout
            skirocAcqPkg::WaitToNext:    limit = WaitToNextCycles;
            default:                     hasLimit = 1'b0;   // Idle and Acquire are open ended
        endcase
    end

    // Phase of duration N ends on its N+1th cycle
    assign PhaseDone = hasLimit && (count >= limit);

endmodule

`default_nettype wire

//--- verilog/skirocAcq.sv
`timescale 1ns/1ps
`default_nettype none

module skirocAcq
#(
    // Phase durations in clock cycles, defaults for 50 MHz
    parameter skirocAcqPkg::countT ResetCycles         = 25,       // 500 ns ASIC reset
    parameter skirocAcqPkg::countT WaitToAcqCycles     = 50,       // 1 us reset to acquisition
    parameter skirocAcqPkg::countT WaitToConvbCycles   = 50,       // 1 us acquisition to conversion
    parameter skirocAcqPkg::countT ConvbCycles         = 2,        // Conversion strobe, 50 ns min
    parameter skirocAcqPkg::countT WaitToReadoutCycles = 250000,   // 5 ms conversion timeout
    parameter skirocAcqPkg::countT ReadoutCycles       = 25,       // 500 ns readout strobe
    parameter skirocAcqPkg::countT WaitToEndCycles     = 250000,   // 5 ms readout timeout
    parameter skirocAcqPkg::countT WaitToNextCycles    = 50        // 1 us before next round
)
(
    input  wire                     Clk,
    input  wire                     Rst_N,
    input  wire                     StartWork,
    input  wire                     Chipsatb,
    input  wire                     EndReadout,
    input  wire                     ExTrig,
    output logic                    Acqing,
    output logic                    StartAcq,
    output logic                    StartConvb,
    output logic                    StartReadout,
    output logic                    PwrOnD,
    output logic                    ResetbAsic,
    output skirocAcqPkg::trigCountT TrigCount
);

    logic                   chipsatbFall;
    logic                   chipsatbRise;
    logic                   endReadoutRise;
    logic                   exTrigRise;
    skirocAcqPkg::seqStateT phase;
    logic                   restart;
    logic                   phaseDone;
    logic                   idle;

    chipSignalSync chipSignalSync_inst
    (
        .Clk            (Clk),
        .Rst_N          (Rst_N),
        .Chipsatb       (Chipsatb),
        .EndReadout     (EndReadout),
        .ExTrig         (ExTrig),
        .ChipsatbFall   (chipsatbFall),
        .ChipsatbRise   (chipsatbRise),
        .EndReadoutRise (endReadoutRise),
        .ExTrigRise     (exTrigRise)
    );

    phaseTimer
    #(
        .ResetCycles         (ResetCycles),
        .WaitToAcqCycles     (WaitToAcqCycles),
        .WaitToConvbCycles   (WaitToConvbCycles),
        .ConvbCycles         (ConvbCycles),
        .WaitToReadoutCycles (WaitToReadoutCycles),
        .ReadoutCycles       (ReadoutCycles),
        .WaitToEndCycles     (WaitToEndCycles),
        .WaitToNextCycles    (WaitToNextCycles)
    )
    phaseTimer_inst
    (
        .Clk       (Clk),
        .Rst_N     (Rst_N),
        .Phase     (phase),
        .Restart   (restart),
        .PhaseDone (phaseDone)
    );

    acqSequencer acqSequencer_inst
    (
        .Clk            (Clk),
        .Rst_N          (Rst_N),
        .StartWork      (StartWork),
        .ChipsatbFall   (chipsatbFall),
        .ChipsatbRise   (chipsatbRise),
        .EndReadoutRise (endReadoutRise),
        .PhaseDone      (phaseDone),
        .Phase          (phase),
        .Restart        (restart),
        .Idle           (idle),
        .Acqing         (Acqing),
        .StartAcq       (StartAcq),
        .StartConvb     (StartConvb),
        .StartReadout   (StartReadout),
        .PwrOnD         (PwrOnD),
        .ResetbAsic     (ResetbAsic)
    );

    trigCounter trigCounter_inst
    (
        .Clk        (Clk),
        .Rst_N      (Rst_N),
        .ExTrigRise (exTrigRise),
        .Idle       (idle),
        .TrigCount  (TrigCount)
    );

endmodule

`default_nettype wire

//--- verilog/skirocAcqPkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared widths and types of the acquisition sequencer
////////////////////////////////////////////////////////////////////////////

package skirocAcqPkg;

    // Phase timer and all phase durations
    localparam int CountWidth = 20;

    typedef logic [CountWidth-1:0] countT;

    // External trigger count, 20 bits as on the readout board
    localparam int TrigWidth = 20;

    typedef logic [TrigWidth-1:0] trigCountT;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer phases
    ////////////////////////////////////////////////////////////////////////////

    // One acquisition cycle walks Reset through WaitToNext, then loops
    typedef enum logic [3:0]
    {
        Idle          = 4'd0,   // Waiting for StartWork
        Reset         = 4'd1,   // ResetbAsic pulse
        WaitToAcq     = 4'd2,
        Acquire       = 4'd3,   // Until the chip memory is full
        WaitToConvb   = 4'd4,
        Convert       = 4'd5,   // StartConvb pulse, active low
        WaitToReadout = 4'd6,   // Until Chipsatb rises or timeout
        Readout       = 4'd7,   // StartReadout pulse
        WaitToEnd     = 4'd8,   // Until EndReadout or timeout
        WaitToNext    = 4'd9
    } seqStateT;

endpackage

`default_nettype wire

//--- verilog/trigCounter.sv
`timescale 1ns/1ps
`default_nettype none

module trigCounter
(
    input  wire                     Clk,
    input  wire                     Rst_N,
    input  wire                     ExTrigRise,
    input  wire                     Idle,
    output skirocAcqPkg::trigCountT TrigCount
);

    ////////////////////////////////////////////////////////////////////////////
    // External trigger count for efficiency measurement
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge Rst_N)
    begin
        if (!Rst_N)
        begin
            TrigCount <= '0;
        end
        else if (ExTrigRise)
        begin
            // An edge is never lost, even on the idle cycle
            TrigCount <= TrigCount + 1'b1;
        end
        else if (Idle)
        begin
            TrigCount <= '0;    // Fresh count for every run
        end
    end

endmodule

`default_nettype wire
